/* run_sim.sh */
#!/bin/sh
# build the page-table walker testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_pager -o sim_pager \
  && ./obj_dir/sim_pager \
  || { echo "simulation failed"; exit 1; }

exit 0

/* source/bus_arbiter.sv */
/*
  shared read port arbiter
  fixed priority with channel 0 first, blocked entirely by bus_hold
  drives the winning walker's address and index onto the port
*/
`timescale 1ns/100ps
`include "pager_consts.svh"

module bus_arbiter (
  input  logic [`N_CHAN-1:0] walk_req,
  input  logic [`N_CHAN-1:0][`PA_WIDTH-1:0] walk_addr,
  input  logic bus_hold,
  output logic [`N_CHAN-1:0] req_bus,
  output logic [`PA_WIDTH-1:0] mem_addr,
  output pager_pkg::chan_id_t mem_tag
);
  import pager_pkg::*;

  always_comb begin
    logic found;
    found = 1'b0;
    req_bus = '0;
    mem_addr = '0;
    mem_tag = '0;
    // lowest requesting channel wins
    for (int i = 0; i < `N_CHAN; i++) begin
      if (walk_req[i] && !found && !bus_hold) begin
        found = 1'b1;
        req_bus[i] = 1'b1;
        mem_addr = walk_addr[i];
        mem_tag = chan_id_t'(i);
      end
    end
  end

endmodule

/* source/pager.sv */
/*
  page-table walker top level
  register block, three walk channels and the read port arbiter
*/
`timescale 1ns/100ps
`include "pager_consts.svh"

module pager (
  input  logic clk,
  input  logic rst,
  input  logic csr_en,
  input  logic [15:0] csr_no,
  input  logic [63:0] csr_data,
  input  logic [`N_CHAN-1:0] new_en,
  input  logic [`N_CHAN-1:0][`VA_WIDTH-1:0] new_addr,
  input  logic bus_hold,
  input  logic mem_hit,
  input  pager_pkg::chan_id_t mem_tag,
  input  pager_pkg::pte_t mem_data,
  output logic [`N_CHAN-1:0] new_can,
  output logic [`N_CHAN-1:0] req_bus,
  output logic [`PA_WIDTH-1:0] mem_addr,
  // index of the channel issuing this cycle's read
  output pager_pkg::chan_id_t req_tag,
  output logic [`N_CHAN-1:0] tlb_wen,
  output logic [`N_CHAN-1:0][`VA_WIDTH-`PAGE_SHIFT-1:0] tlb_vpn,
  output pager_pkg::tlb_entry_t [`N_CHAN-1:0] tlb_entry
);

  logic [63:0] root0;
  logic [63:0] root1;
  logic paging_en;
  logic [`N_CHAN-1:0] walk_req;
  logic [`N_CHAN-1:0][`PA_WIDTH-1:0] walk_addr;

  pager_csr u_csr (
    .clk(clk),
    .rst(rst),
    .csr_en(csr_en),
    .csr_no(csr_no),
    .csr_data(csr_data),
    .root0(root0),
    .root1(root1),
    .paging_en(paging_en)
  );

  // responses go to every walker, the tag picks the taker
  for (genvar k = 0; k < `N_CHAN; k++) begin : g_chan
    walk_channel #(
      .CHAN_ID(k)
    ) u_walk (
      .clk(clk),
      .rst(rst),
      .new_en(new_en[k]),
      .new_addr(new_addr[k]),
      .root0(root0),
      .root1(root1),
      .paging_en(paging_en),
      .grant(req_bus[k]),
      .mem_hit(mem_hit),
      .mem_tag(mem_tag),
      .mem_data(mem_data),
      .new_can(new_can[k]),
      .walk_req(walk_req[k]),
      .walk_addr(walk_addr[k]),
      .tlb_wen(tlb_wen[k]),
      .tlb_vpn(tlb_vpn[k]),
      .tlb_entry(tlb_entry[k])
    );
  end

  bus_arbiter u_arb (
    .walk_req(walk_req),
    .walk_addr(walk_addr),
    .bus_hold(bus_hold),
    .req_bus(req_bus),
    .mem_addr(mem_addr),
    .mem_tag(req_tag)
  );

endmodule

/* source/pager_consts.svh */
/*
  page-table walker constants
  address widths, walk geometry, entry flag positions and register numbers
*/
`ifndef PAGER_CONSTS_SVH
`define PAGER_CONSTS_SVH

// virtual and physical address widths
`define VA_WIDTH 48
`define PA_WIDTH 44

// walk geometry, 8 KiB pages and 10-bit indices
`define PAGE_SHIFT 13
`define LVL_BITS 10
`define LVL_COUNT 3
`define LVL_LAST (`LVL_COUNT - 1)
// only this level may hold an 8 MiB huge leaf
`define LVL_HUGE 1
`define ROOT_SEL_BIT 43

`define N_CHAN 3

// root pointer register numbers
`define CSR_PAGE0 16'h0c00
`define CSR_PAGE1 16'h0c01

// entry flag bits
`define PTE_VALID 0
`define PTE_WRITE 1
`define PTE_SYS 2
`define PTE_ACC 3
`define PTE_DIRTY 4
`define PTE_GLOBAL 5
`define PTE_HUGE 6

`endif

/* source/pager_csr.sv */
/*
  pager register block
  holds the two root pointers and the paging switch, which turns on
  as soon as either root is written
*/
`timescale 1ns/100ps
`include "pager_consts.svh"

module pager_csr (
  input  logic clk,
  input  logic rst,
  input  logic csr_en,
  input  logic [15:0] csr_no,
  input  logic [63:0] csr_data,
  output logic [63:0] root0,
  output logic [63:0] root1,
  output logic paging_en
);

  logic wr_page0;
  logic wr_page1;

  // register number decode
  assign wr_page0 = csr_en && (csr_no == `CSR_PAGE0);
  assign wr_page1 = csr_en && (csr_no == `CSR_PAGE1);

  always_ff @(posedge clk) begin
    if (rst) begin
      root0 <= '0;
      root1 <= '0;
      paging_en <= 1'b0;
    end else begin
      if (wr_page0) begin
        root0 <= csr_data;
      end
      if (wr_page1) begin
        root1 <= csr_data;
      end
      // no way back to paging off short of reset
      if (wr_page0 || wr_page1) begin
        paging_en <= 1'b1;
      end
    end
  end

endmodule

/* source/pager_pkg.sv */
/*
  page-table walker types
  the page-table entry in its table and leaf views, the translation
  entry written to the TLB and the channel index
*/
`include "pager_consts.svh"

package pager_pkg;

  // physical page number width
  localparam int PPN_W = `PA_WIDTH - `PAGE_SHIFT;

  typedef logic [1:0] chan_id_t;

  // entry pointing at the next table level
  typedef struct packed {
    logic [63-`PA_WIDTH:0] rsvd;
    logic [PPN_W-1:0] next_base;
    logic [5:0] avail;
    logic [6:0] flags;
  } pte_table_t;

  // entry mapping a page
  typedef struct packed {
    logic [63-`PA_WIDTH:0] rsvd;
    logic [PPN_W-1:0] ppn;
    logic [5:0] avail;
    logic [6:0] flags;
  } pte_leaf_t;

  // one memory word, decoded by the walk level
  typedef union packed {
    pte_table_t tbl;
    pte_leaf_t leaf;
  } pte_t;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic global;
    logic dirty;
    logic accessed;
    logic sys;
    logic writable;
    logic valid;
  } tlb_entry_t;

endpackage

/* source/walk_channel.sv */
/*
  single-channel page-table walker
  takes one virtual address at a time, reads up to three table levels
  through the shared read port and writes one translation entry
  with paging off the entry maps the address onto itself
*/
`timescale 1ns/100ps
`include "pager_consts.svh"

module walk_channel #(
  parameter int CHAN_ID = 0
) (
  input  logic clk,
  input  logic rst,
  input  logic new_en,
  input  logic [`VA_WIDTH-1:0] new_addr,
  input  logic [63:0] root0,
  input  logic [63:0] root1,
  input  logic paging_en,
  input  logic grant,
  input  logic mem_hit,
  input  pager_pkg::chan_id_t mem_tag,
  input  pager_pkg::pte_t mem_data,
  output logic new_can,
  output logic walk_req,
  output logic [`PA_WIDTH-1:0] walk_addr,
  output logic tlb_wen,
  output logic [`VA_WIDTH-`PAGE_SHIFT-1:0] tlb_vpn,
  output pager_pkg::tlb_entry_t tlb_entry
);
  import pager_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_DONE
  } state_t;

  state_t state;

  // walk payload
  logic [`VA_WIDTH-1:0] va;
  logic [PPN_W-1:0] base;
  logic [1:0] level;

  logic accept;
  logic resp;
  logic pte_valid;
  logic is_leaf;
  logic [5:0] idx_lsb;
  logic [`LVL_BITS-1:0] idx;
  tlb_entry_t ident_entry;
  tlb_entry_t leaf_entry;

  assign accept = new_en && new_can;
  // response is ours only while waiting and tagged with our index
  assign resp = (state == ST_WAIT) && mem_hit && (mem_tag == chan_id_t'(CHAN_ID));

  assign new_can = (state == ST_IDLE);
  assign walk_req = (state == ST_REQ);
  assign tlb_wen = (state == ST_DONE);
  assign tlb_vpn = va[`VA_WIDTH-1:`PAGE_SHIFT];

  // level 0 takes bits 42:33, level 2 takes bits 22:13
  assign idx_lsb = 6'(`PAGE_SHIFT + `LVL_BITS * (`LVL_LAST - int'(level)));
  assign idx = va[idx_lsb +: `LVL_BITS];

  // entries are 8 bytes
  assign walk_addr = {base, idx, 3'b000};

  assign pte_valid = mem_data.tbl.flags[`PTE_VALID];
  assign is_leaf = (level == 2'(`LVL_LAST)) ||
                   ((level == 2'(`LVL_HUGE)) && mem_data.leaf.flags[`PTE_HUGE]);

  // identity map for paging off
  always_comb begin
    ident_entry = '0;
    ident_entry.ppn = new_addr[`PA_WIDTH-1:`PAGE_SHIFT];
    ident_entry.valid = 1'b1;
    ident_entry.writable = 1'b1;
    ident_entry.accessed = 1'b1;
  end

  always_comb begin
    leaf_entry.ppn = mem_data.leaf.ppn;
    // 8 MiB page, low index comes straight from the address
    if (level == 2'(`LVL_HUGE)) begin
      leaf_entry.ppn[`LVL_BITS-1:0] = va[`PAGE_SHIFT +: `LVL_BITS];
    end
    leaf_entry.valid = mem_data.leaf.flags[`PTE_VALID];
    leaf_entry.writable = mem_data.leaf.flags[`PTE_WRITE];
    leaf_entry.sys = mem_data.leaf.flags[`PTE_SYS];
    leaf_entry.accessed = mem_data.leaf.flags[`PTE_ACC];
    leaf_entry.dirty = mem_data.leaf.flags[`PTE_DIRTY];
    leaf_entry.global = mem_data.leaf.flags[`PTE_GLOBAL];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= paging_en ? ST_REQ : ST_DONE;
          end
        end
        ST_REQ: begin
          // hold the request until the arbiter picks us
          if (grant) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (resp) begin
            state <= (!pte_valid || is_leaf) ? ST_DONE : ST_REQ;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      va <= new_addr;
      level <= '0;
      // bit 43 picks the root table
      if (new_addr[`ROOT_SEL_BIT]) begin
        base <= root1[`PA_WIDTH-1:`PAGE_SHIFT];
      end else begin
        base <= root0[`PA_WIDTH-1:`PAGE_SHIFT];
      end
      if (!paging_en) begin
        tlb_entry <= ident_entry;
      end
    end else if (resp) begin
      if (!pte_valid) begin
        // fault, entry goes out with valid clear
        tlb_entry <= '0;
      end else if (is_leaf) begin
        tlb_entry <= leaf_entry;
      end else begin
        base <= mem_data.tbl.next_base;
        level <= level + 2'd1;
      end
    end
  end

endmodule

/* src.f */
+incdir+source
source/pager_pkg.sv
source/pager_csr.sv
source/walk_channel.sv
source/bus_arbiter.sv
source/pager.sv
test/tb_page_mem.sv
test/tb_pager.sv

/* test/tb_page_mem.sv */
/*
  behavioral page-table memory for the walker testbench
  sparse image loaded through a write port, answers each issued read
  after 1 to 4 cycles, one outstanding read per tag
*/
`timescale 1ns/100ps

module tb_page_mem (
  input  logic clk,
  input  logic rst,
  input  logic wr_en,
  input  logic [43:0] wr_addr,
  input  logic [63:0] wr_data,
  input  logic [2:0] req_bus,
  input  logic [43:0] req_addr,
  input  logic [1:0] req_tag,
  output logic rd_hit,
  output logic [1:0] rd_tag,
  output logic [63:0] rd_data
);

  logic [63:0] mem [logic [43:0]];
  logic pend [3];
  logic [43:0] pend_addr [3];
  int pend_wait [3];
  int seed = 32'h71fa;

  initial begin
    rd_hit = 1'b0;
    rd_tag = 2'd0;
    rd_data = 64'h0;
    for (int i = 0; i < 3; i++) begin
      pend[i] = 1'b0;
      pend_addr[i] = 44'h0;
      pend_wait[i] = 0;
    end
  end

  always @(posedge clk) begin
    logic sent;
    if (wr_en) begin
      mem[wr_addr] = wr_data;
    end
    // capture the read issued in the cycle that just ended
    if (!rst && req_bus != 3'b000) begin
      pend[req_tag] = 1'b1;
      pend_addr[req_tag] = req_addr;
      pend_wait[req_tag] = 1 + int'($unsigned($random(seed)) % 4);
    end
    #1;
    sent = 1'b0;
    rd_hit = 1'b0;
    // one response per cycle, lower tag first when two are due
    for (int i = 0; i < 3; i++) begin
      if (pend[i]) begin
        if (pend_wait[i] <= 1 && !sent) begin
          rd_hit = 1'b1;
          rd_tag = 2'(i);
          rd_data = mem.exists(pend_addr[i]) ? mem[pend_addr[i]] : 64'h0;
          pend[i] = 1'b0;
          sent = 1'b1;
        end else if (pend_wait[i] > 1) begin
          pend_wait[i] = pend_wait[i] - 1;
        end
      end
    end
  end

endmodule

/* test/tb_pager.sv */
/*
  page-table walker testbench
  directed tests for paging off, three-level walks, huge pages,
  faults and read port arbitration, checked against a reference walk
*/
`timescale 1ns/100ps
`include "pager_consts.svh"

module tb_pager;
  import pager_pkg::*;

  logic clk;
  logic rst;
  logic csr_en;
  logic [15:0] csr_no;
  logic [63:0] csr_data;
  logic [2:0] new_en;
  logic [2:0][47:0] new_addr;
  logic bus_hold;
  logic rsp_hit;
  logic [1:0] rsp_tag;
  logic [63:0] rsp_data;
  logic [2:0] new_can;
  logic [2:0] req_bus;
  logic [43:0] mem_addr;
  logic [1:0] req_tag;
  logic [2:0] tlb_wen;
  logic [2:0][34:0] tlb_vpn;
  tlb_entry_t [2:0] tlb_entry;
  logic wr_en;
  logic [43:0] wr_addr;
  logic [63:0] wr_data;

  // reference copy of the table image
  logic [63:0] img [logic [43:0]];
  logic [63:0] root0_val;
  logic [63:0] root1_val;
  logic paging_on;
  logic [45:0] issued [$];
  logic [43:0] ref_reads [$];
  // reads the DUT issued for the last checked walk
  int walk_reads;

  pager u_dut (
    .clk(clk), .rst(rst), .csr_en(csr_en), .csr_no(csr_no), .csr_data(csr_data),
    .new_en(new_en), .new_addr(new_addr), .bus_hold(bus_hold),
    .mem_hit(rsp_hit), .mem_tag(rsp_tag), .mem_data(rsp_data),
    .new_can(new_can), .req_bus(req_bus), .mem_addr(mem_addr), .req_tag(req_tag),
    .tlb_wen(tlb_wen), .tlb_vpn(tlb_vpn), .tlb_entry(tlb_entry)
  );

  tb_page_mem u_mem (
    .clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .req_bus(req_bus), .req_addr(mem_addr), .req_tag(req_tag),
    .rd_hit(rsp_hit), .rd_tag(rsp_tag), .rd_data(rsp_data)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else
      stop_run($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
  endtask

  // every issued read, tagged with its channel
  always @(posedge clk) begin
    if (!rst && req_bus != 3'b000) begin
      assert (req_bus == (3'b001 << req_tag)) else
        stop_run("read port grant is not one-hot or disagrees with its tag");
      assert (!bus_hold) else
        stop_run("a read was issued while bus_hold was high");
      issued.push_back({req_tag, mem_addr});
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [47:0] make_va(input logic sel, input logic [9:0] i0,
                                          input logic [9:0] i1, input logic [9:0] i2,
                                          input logic [12:0] off);
    return {4'h0, sel, i0, i1, i2, off};
  endfunction

  function automatic logic [63:0] make_pte(input logic [43:0] a, input logic [6:0] f);
    return {20'h0, a[43:13], 6'h0, f};
  endfunction

  // walk over the reference image, also lists the expected reads
  function automatic logic [36:0] expected_entry(input logic [47:0] va);
    logic [30:0] base;
    logic [30:0] ppn;
    logic [63:0] pte;
    logic [43:0] a;
    logic done;
    logic [36:0] ent;
    ref_reads.delete();
    if (!paging_on) begin
      return {va[43:13], 6'b001011};
    end
    ent = '0;
    done = 1'b0;
    base = va[43] ? root1_val[43:13] : root0_val[43:13];
    for (int lvl = 0; lvl < 3; lvl++) begin
      if (!done) begin
        a = {base, va[42 - 10 * lvl -: 10], 3'b000};
        ref_reads.push_back(a);
        pte = img.exists(a) ? img[a] : 64'h0;
        if (!pte[0]) begin
          ent = '0;
          done = 1'b1;
        end else if (lvl == 2 || (lvl == 1 && pte[6])) begin
          ppn = pte[43:13];
          if (lvl == 1) begin
            ppn[9:0] = va[22:13];
          end
          ent = {ppn, pte[5:0]};
          done = 1'b1;
        end else begin
          base = pte[43:13];
        end
      end
    end
    return ent;
  endfunction

  task automatic put_word(input logic [43:0] a, input logic [63:0] d);
    img[a] = d;
    wr_en = 1'b1;
    wr_addr = a;
    wr_data = d;
    tick();
    wr_en = 1'b0;
  endtask

  task automatic write_root(input logic [15:0] no, input logic [63:0] d);
    csr_en = 1'b1;
    csr_no = no;
    csr_data = d;
    tick();
    csr_en = 1'b0;
    if (no == `CSR_PAGE0) root0_val = d;
    else root1_val = d;
    paging_on = 1'b1;
  endtask

  task automatic start_req(input int ch, input logic [47:0] va, input string name);
    int t;
    t = 0;
    while (!new_can[ch]) begin
      tick();
      t++;
      assert (t < 200) else stop_run({name, ": channel never became ready"});
    end
    new_addr[ch] = va;
    new_en[ch] = 1'b1;
    tick();
    new_en[ch] = 1'b0;
  endtask

  // compare entry, page number and this channel's reads
  task automatic check_walk(input int ch, input logic [47:0] va, input string name);
    logic [36:0] exp;
    logic [43:0] got [$];
    logic [45:0] rest [$];
    exp = expected_entry(va);
    check_val({name, " entry"}, 64'(exp), 64'(tlb_entry[ch]));
    check_val({name, " vpn"}, 64'(va[47:13]), 64'(tlb_vpn[ch]));
    foreach (issued[i]) begin
      if (issued[i][45:44] == 2'(ch)) got.push_back(issued[i][43:0]);
      else rest.push_back(issued[i]);
    end
    issued = rest;
    walk_reads = got.size();
    check_val({name, " read count"}, 64'(ref_reads.size()), 64'(got.size()));
    foreach (ref_reads[i]) begin
      check_val({name, " read address"}, 64'(ref_reads[i]), 64'(got[i]));
    end
  endtask

  task automatic single_walk(input int ch, input logic [47:0] va, input string name);
    int t;
    start_req(ch, va, name);
    t = 0;
    while (!tlb_wen[ch]) begin
      tick();
      t++;
      assert (t < 200) else stop_run({name, ": no translation entry was written"});
    end
    check_walk(ch, va, name);
    tick();
    assert (new_can[ch] && !tlb_wen[ch]) else
      stop_run({name, ": channel did not return to ready after its entry"});
  endtask

  task automatic test_paging_off();
    logic [47:0] va;
    va = make_va(1'b1, 10'h2a5, 10'h013, 10'h3f0, 13'h0777);
    check_val("reset new_can", 64'(3'b111), 64'(new_can));
    check_val("reset req_bus", 64'h0, 64'(req_bus));
    check_val("reset tlb_wen", 64'h0, 64'(tlb_wen));
    start_req(0, va, "paging_off");
    // one cycle after the accepting edge
    check_val("paging_off tlb_wen", 64'(3'b001), 64'(tlb_wen));
    check_walk(0, va, "paging_off");
    tick();
    check_val("paging_off pulse end", 64'h0, 64'(tlb_wen));
    assert (issued.size() == 0) else stop_run("paging_off: a memory read was issued");
  endtask

  task automatic test_three_level();
    single_walk(1, make_va(1'b0, 10'd5, 10'd7, 10'd9, 13'h1234), "walk_root0");
    single_walk(2, make_va(1'b1, 10'd3, 10'd4, 10'd6, 13'h0042), "walk_root1");
  endtask

  task automatic test_huge_page();
    logic [47:0] va;
    va = make_va(1'b0, 10'd5, 10'd2, 10'h155, 13'h0abc);
    single_walk(0, va, "huge_page");
    // walk stops at level 1, low page bits come from the address
    check_val("huge_page reads", 64'd2, 64'(walk_reads));
    check_val("huge_page low ppn", 64'(va[22:13]), 64'(tlb_entry[0].ppn[9:0]));
  endtask

  task automatic test_fault();
    single_walk(0, make_va(1'b0, 10'd9, 10'd1, 10'd1, 13'h0), "fault_l0");
    single_walk(2, make_va(1'b0, 10'd5, 10'd11, 10'd1, 13'h0), "fault_l1");
  endtask

  task automatic test_arbitration();
    logic [2:0][47:0] va;
    logic [2:0] done;
    int t;
    va[0] = make_va(1'b0, 10'd5, 10'd7, 10'd9, 13'h0010);
    va[1] = make_va(1'b1, 10'd3, 10'd4, 10'd6, 13'h0020);
    va[2] = make_va(1'b0, 10'd5, 10'd2, 10'h0aa, 13'h0030);
    // nothing may be read once the earlier walks have ended
    assert (issued.size() == 0) else
      stop_run("arbitration: a read was issued after an earlier walk ended");
    bus_hold = 1'b1;
    new_addr = va;
    new_en = 3'b111;
    tick();
    new_en = 3'b000;
    repeat (3) begin
      check_val("hold req_bus", 64'h0, 64'(req_bus));
      tick();
    end
    bus_hold = 1'b0;
    #1;
    check_val("first grant", 64'(3'b001), 64'(req_bus));
    done = 3'b000;
    t = 0;
    while (done != 3'b111) begin
      for (int ch = 0; ch < 3; ch++) begin
        if (tlb_wen[ch]) begin
          check_walk(ch, va[ch], $sformatf("arb_ch%0d", ch));
          done[ch] = 1'b1;
        end
      end
      tick();
      t++;
      assert (t < 300) else stop_run("arbitration: not every channel finished its walk");
    end
  endtask

  initial begin
    rst = 1'b1;
    csr_en = 1'b0;
    csr_no = 16'h0;
    csr_data = 64'h0;
    new_en = 3'b000;
    new_addr = '0;
    bus_hold = 1'b0;
    wr_en = 1'b0;
    wr_addr = 44'h0;
    wr_data = 64'h0;
    root0_val = 64'h0;
    root1_val = 64'h0;
    paging_on = 1'b0;
    walk_reads = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_paging_off();
    // root0 tables at 1M, root1 tables at 2M
    put_word(44'h00000100000 + 44'd40, make_pte(44'h00000300000, 7'b0000001));
    put_word(44'h00000300000 + 44'd56, make_pte(44'h00000400000, 7'b0000001));
    put_word(44'h00000400000 + 44'd72, make_pte(44'h12345678000, 7'b0011011));
    put_word(44'h00000300000 + 44'd16, make_pte(44'h00a00ffe000, 7'b1000011));
    put_word(44'h00000200000 + 44'd24, make_pte(44'h00000500000, 7'b0000001));
    put_word(44'h00000500000 + 44'd32, make_pte(44'h00000600000, 7'b0000001));
    put_word(44'h00000600000 + 44'd48, make_pte(44'h0f0f0f0e000, 7'b0100101));
    write_root(`CSR_PAGE0, 64'h00000100000);
    write_root(`CSR_PAGE1, 64'h00000200000);
    tick();
    test_three_level();
    test_huge_page();
    test_fault();
    test_arbitration();
    $display("RESULT: PASS");
    $finish;
  end

endmodule
